//--- Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, check $(LOG)"
	@echo "make clean  remove obj_dir and $(LOG)"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal \
	  --top-module tb_rv_decode_stage -f rv_decode_stage.f -o tb_sim
	./obj_dir/tb_sim > $(LOG) 2>&1 || echo "TESTBENCH FAILED" >> $(LOG)
	@cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

//--- hw/ctrl_decoder.sv
// funct-level decoder producing the registered control word
`timescale 1ns/100ps

module ctrl_decoder import rv_isa_pkg::*; import rv_ctrl_pkg::*; (
  input  logic        clk,
  input  logic        arst_n_i,
  input  logic        q_valid_i,
  input  class_insn_t q_insn_i,
  input  logic        stall_i,       // holds the queue
  output logic        pop_o,
  output logic        ctrl_valid_o,
  output rv_ctrl_t    ctrl_o
);

  insn_u      insn;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [11:0] funct12;
  logic [2:0] st_funct3;
  rv_ctrl_t   ctrl_d;

  assign insn      = q_insn_i.insn;
  assign funct3    = insn.r_fmt.funct3;
  assign funct7    = insn.r_fmt.funct7;
  assign funct12   = insn.i_fmt.imm12;   // system funct12
  assign st_funct3 = insn.s_fmt.funct3;
  assign pop_o     = q_valid_i & ~stall_i;

  //////////////////////////////////////////////////////////
  // decode
  //////////////////////////////////////////////////////////
  always_comb begin
    // defaults are reg/reg operands, I imm, word access and nothing enabled
    ctrl_d        = '0;
    ctrl_d.alu_op = ALU_SLTU;

    unique case (q_insn_i.cls)
      CLS_JAL,
      CLS_JALR: begin              // link address pc+4 only
        ctrl_d.jump      = 1'b1;
        ctrl_d.op_a_sel  = OP_A_CURRPC;
        ctrl_d.op_b_sel  = OP_B_IMM;
        ctrl_d.imm_b_sel = IMM_B_PCINCR;
        ctrl_d.alu_op    = ALU_ADD;
        ctrl_d.rf_we     = 1'b1;
        if (q_insn_i.cls == CLS_JALR && funct3 != 3'b000)
          ctrl_d.illegal = 1'b1;
      end

      CLS_BRANCH: begin
        ctrl_d.branch = 1'b1;        // compare rs1/rs2
        unique case (funct3)
          3'b000:  ctrl_d.alu_op = ALU_EQ;
          3'b001:  ctrl_d.alu_op = ALU_NE;
          3'b100:  ctrl_d.alu_op = ALU_LTS;
          3'b101:  ctrl_d.alu_op = ALU_GES;
          3'b110:  ctrl_d.alu_op = ALU_LTU;
          3'b111:  ctrl_d.alu_op = ALU_GEU;
          default: ctrl_d.illegal = 1'b1;
        endcase
      end

      CLS_LOAD: begin
        ctrl_d.mem_req      = 1'b1;
        ctrl_d.rf_we        = 1'b1;
        ctrl_d.alu_op       = ALU_ADD;   // address = rs1 + imm
        ctrl_d.op_b_sel     = OP_B_IMM;
        ctrl_d.mem_sign_ext = ~funct3[2];
        unique case (funct3)
          3'b000, 3'b100: ctrl_d.mem_type = MEM_BYTE;
          3'b001, 3'b101: ctrl_d.mem_type = MEM_HALF;
          3'b010:         ctrl_d.mem_type = MEM_WORD;
          default:        ctrl_d.illegal  = 1'b1;  // ld and custom loads
        endcase
      end

      CLS_STORE: begin
        ctrl_d.mem_req   = 1'b1;
        ctrl_d.mem_we    = 1'b1;
        ctrl_d.alu_op    = ALU_ADD;
        ctrl_d.op_b_sel  = OP_B_IMM;
        ctrl_d.imm_b_sel = IMM_B_S;
        if (st_funct3[2])
          ctrl_d.illegal = 1'b1;        // no reg-offset store
        unique case (st_funct3[1:0])
          2'b00:   ctrl_d.mem_type = MEM_BYTE;
          2'b01:   ctrl_d.mem_type = MEM_HALF;
          2'b10:   ctrl_d.mem_type = MEM_WORD;
          default: ctrl_d.illegal  = 1'b1;
        endcase
      end

      CLS_LUI: begin                  // 0 + U imm
        ctrl_d.op_a_sel  = OP_A_IMM;
        ctrl_d.op_b_sel  = OP_B_IMM;
        ctrl_d.imm_a_sel = IMM_A_ZERO;
        ctrl_d.imm_b_sel = IMM_B_U;
        ctrl_d.alu_op    = ALU_ADD;
        ctrl_d.rf_we     = 1'b1;
      end

      CLS_AUIPC: begin                // pc + U imm
        ctrl_d.op_a_sel  = OP_A_CURRPC;
        ctrl_d.op_b_sel  = OP_B_IMM;
        ctrl_d.imm_b_sel = IMM_B_U;
        ctrl_d.alu_op    = ALU_ADD;
        ctrl_d.rf_we     = 1'b1;
      end

      CLS_OP_IMM: begin
        ctrl_d.op_b_sel = OP_B_IMM;
        ctrl_d.rf_we    = 1'b1;
        unique case (funct3)
          3'b000: ctrl_d.alu_op = ALU_ADD;
          3'b010: ctrl_d.alu_op = ALU_SLTS;
          3'b011: ctrl_d.alu_op = ALU_SLTU;
          3'b100: ctrl_d.alu_op = ALU_XOR;
          3'b110: ctrl_d.alu_op = ALU_OR;
          3'b111: ctrl_d.alu_op = ALU_AND;
          3'b001: begin
            ctrl_d.alu_op = ALU_SLL;
            if (funct7 != 7'h00)
              ctrl_d.illegal = 1'b1;   // shamt[5] or junk
          end
          default: begin               // 101 is srli/srai
            if (funct7 == 7'h00)
              ctrl_d.alu_op = ALU_SRL;
            else if (funct7 == 7'h20)
              ctrl_d.alu_op = ALU_SRA;
            else
              ctrl_d.illegal = 1'b1;
          end
        endcase
      end

      CLS_OP: begin
        ctrl_d.rf_we = 1'b1;
        unique case (funct7)
          7'h00: begin
            unique case (funct3)
              3'b000: ctrl_d.alu_op = ALU_ADD;
              3'b001: ctrl_d.alu_op = ALU_SLL;
              3'b010: ctrl_d.alu_op = ALU_SLTS;
              3'b011: ctrl_d.alu_op = ALU_SLTU;
              3'b100: ctrl_d.alu_op = ALU_XOR;
              3'b101: ctrl_d.alu_op = ALU_SRL;
              3'b110: ctrl_d.alu_op = ALU_OR;
              default: ctrl_d.alu_op = ALU_AND;
            endcase
          end
          7'h20: begin
            if (funct3 == 3'b000)
              ctrl_d.alu_op = ALU_SUB;
            else if (funct3 == 3'b101)
              ctrl_d.alu_op = ALU_SRA;
            else
              ctrl_d.illegal = 1'b1;
          end
          7'h01: begin                 // rv32m
            ctrl_d.md_en  = 1'b1;
            ctrl_d.alu_op = ALU_ADD;
            unique case (funct3)
              3'b000:                 ctrl_d.md_op = MD_MULL;
              3'b001, 3'b010, 3'b011: ctrl_d.md_op = MD_MULH;
              3'b100, 3'b101:         ctrl_d.md_op = MD_DIV;
              default:                ctrl_d.md_op = MD_REM;
            endcase
            unique case (funct3)
              3'b001, 3'b100, 3'b110: ctrl_d.md_signed = 2'b11;  // mulh div rem
              3'b010:                 ctrl_d.md_signed = 2'b01;  // mulhsu
              default:                ctrl_d.md_signed = 2'b00;  // mul and unsigned forms
            endcase
          end
          default: ctrl_d.illegal = 1'b1;
        endcase
      end

      CLS_SYSTEM: begin
        if (funct3 == 3'b000) begin
          unique case (funct12)
            12'h000: ctrl_d.ecall  = 1'b1;
            12'h001: ctrl_d.ebreak = 1'b1;
            12'h302: ctrl_d.mret   = 1'b1;
            12'h105: ctrl_d.wfi    = 1'b1;
            default: ctrl_d.illegal = 1'b1;
          endcase
        end else begin
          // csr read/modify with the address in the I imm
          ctrl_d.csr_access = 1'b1;
          ctrl_d.rf_we      = 1'b1;
          ctrl_d.op_b_sel   = OP_B_IMM;
          ctrl_d.imm_a_sel  = IMM_A_Z;
          ctrl_d.op_a_sel   = funct3[2] ? OP_A_IMM : OP_A_REG;
          unique case (funct3[1:0])
            2'b01:   ctrl_d.csr_op  = CSR_WRITE;
            2'b10:   ctrl_d.csr_op  = CSR_SET;
            2'b11:   ctrl_d.csr_op  = CSR_CLEAR;
            default: ctrl_d.illegal = 1'b1;
          endcase
        end
      end

      default: ctrl_d.illegal = 1'b1;  // classifier gave up
    endcase

    // an illegal word must not change any state
    if (ctrl_d.illegal) begin
      ctrl_d.rf_we   = 1'b0;
      ctrl_d.mem_req = 1'b0;
      ctrl_d.md_en   = 1'b0;
      ctrl_d.jump    = 1'b0;
      ctrl_d.branch  = 1'b0;
      ctrl_d.csr_op  = CSR_NONE;
    end
  end

  //////////////////////////////////////////////////////////
  // output register
  //////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ctrl_valid_o <= 1'b0;
      ctrl_o       <= '0;
    end else begin
      ctrl_valid_o <= pop_o;
      if (pop_o)
        ctrl_o <= ctrl_d;             // held otherwise
    end
  end

  // no illegal write-back on the registered word
  a_illegal_no_we: assert property (
    @(posedge clk) disable iff (!arst_n_i)
    !(ctrl_o.illegal && ctrl_o.rf_we)
  ) else $error("ctrl_decoder: illegal word with rf_we on ctrl_o");

endmodule

//--- hw/insn_classifier.sv
// instruction input register with major-opcode classification
`timescale 1ns/100ps

module insn_classifier import rv_isa_pkg::*; (
  input  logic        clk,
  input  logic        arst_n_i,
  input  logic        instr_valid_i,  // one strobe per word
  input  insn_u       instr_i,
  output logic        cls_valid_o,    // push strobe to queue
  output class_insn_t cls_insn_o
);

  insn_class_e cls_d;
  logic [6:0]  opcode;

  assign opcode = instr_i.u_fmt.opcode;  // same bits in every view

  //////////////////////////////////////////////////////////
  // opcode to class
  //////////////////////////////////////////////////////////
  always_comb begin
    cls_d = CLS_ILLEGAL;  // unknown or compressed space
    if (opcode[1:0] == 2'b11) begin
      case (opcode)
        OPC_LUI:    cls_d = CLS_LUI;
        OPC_AUIPC:  cls_d = CLS_AUIPC;
        OPC_JAL:    cls_d = CLS_JAL;
        OPC_JALR:   cls_d = CLS_JALR;
        OPC_BRANCH: cls_d = CLS_BRANCH;
        OPC_LOAD:   cls_d = CLS_LOAD;
        OPC_STORE:  cls_d = CLS_STORE;
        OPC_OP_IMM: cls_d = CLS_OP_IMM;
        OPC_OP:     cls_d = CLS_OP;
        OPC_SYSTEM: cls_d = CLS_SYSTEM;
        default:    cls_d = CLS_ILLEGAL;
      endcase
    end
  end

  //////////////////////////////////////////////////////////
  // registers
  //////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cls_valid_o <= 1'b0;
    end else begin
      cls_valid_o <= instr_valid_i;  // latency 1
    end
  end

  // payload only, loaded on a strobe
  always_ff @(posedge clk) begin
    if (instr_valid_i) begin
      cls_insn_o.insn <= instr_i;
      cls_insn_o.cls  <= cls_d;
    end
  end

endmodule

//--- hw/insn_queue.sv
// in-order fwft queue of classified instructions
`timescale 1ns/100ps

module insn_queue import rv_isa_pkg::*; #(
  parameter int QUEUE_DEPTH = 4  // power of two, >= 2
) (
  input  logic        clk,
  input  logic        arst_n_i,
  input  logic        push_i,
  input  class_insn_t push_data_i,
  input  logic        pop_i,
  output logic        valid_o,      // level, not empty
  output class_insn_t data_o,       // head entry
  output logic        full_o
);

  localparam int PTR_W = $clog2(QUEUE_DEPTH);

  class_insn_t      mem [QUEUE_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;          // one extra bit for full
  logic             push_ok;
  logic             pop_ok;

  assign valid_o = (count != '0);
  assign full_o  = (count == (PTR_W+1)'(QUEUE_DEPTH));
  assign push_ok = push_i & ~full_o;  // overflow is dropped
  assign pop_ok  = pop_i & valid_o;
  assign data_o  = mem[rd_ptr];       // fall-through read

  //////////////////////////////////////////////////////////
  // storage
  //////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (push_ok) begin
      mem[wr_ptr] <= push_data_i;
    end
  end

  //////////////////////////////////////////////////////////
  // pointers and occupancy
  //////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_ok) wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
      if (pop_ok)  rd_ptr <= rd_ptr + 1'b1;
      case ({push_ok, pop_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;           // both or neither
      endcase
    end
  end

  // source must respect full with its slack
  a_no_push_full: assert property (
    @(posedge clk) disable iff (!arst_n_i) !(push_i && full_o)
  ) else $error("insn_queue: push while full, entry dropped");

  // decoder only pops on a valid head
  a_no_pop_empty: assert property (
    @(posedge clk) disable iff (!arst_n_i) !(pop_i && !valid_o)
  ) else $error("insn_queue: pop while empty");

endmodule

//--- hw/rv_ctrl_pkg.sv
// control-side enums and the decoded control word
package rv_ctrl_pkg;

  //////////////////////////////////////////////////////////
  // alu and operand muxes
  //////////////////////////////////////////////////////////
  typedef enum logic [4:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_XOR,
    ALU_OR,
    ALU_AND,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLTS,
    ALU_SLTU,
    ALU_EQ,    // branch compares from here
    ALU_NE,
    ALU_LTS,
    ALU_GES,
    ALU_LTU,
    ALU_GEU
  } alu_op_e;

  typedef enum logic [1:0] {
    OP_A_REG,
    OP_A_CURRPC,
    OP_A_IMM
  } op_a_sel_e;

  typedef enum logic {
    OP_B_REG,
    OP_B_IMM
  } op_b_sel_e;

  typedef enum logic {
    IMM_A_ZERO,
    IMM_A_Z     // rs1 field as zero-extended imm
  } imm_a_sel_e;

  typedef enum logic [1:0] {
    IMM_B_I,
    IMM_B_S,
    IMM_B_U,
    IMM_B_PCINCR  // constant 4 for link address
  } imm_b_sel_e;

  //////////////////////////////////////////////////////////
  // mul/div, csr, memory
  //////////////////////////////////////////////////////////
  typedef enum logic [1:0] {
    MD_MULL,
    MD_MULH,
    MD_DIV,
    MD_REM
  } md_op_e;

  typedef enum logic [1:0] {
    CSR_NONE,
    CSR_WRITE,
    CSR_SET,
    CSR_CLEAR
  } csr_op_e;

  typedef enum logic [1:0] {
    MEM_WORD = 2'b00,
    MEM_HALF = 2'b01,
    MEM_BYTE = 2'b10
  } mem_type_e;

  // full decoded control word of 32 bits
  typedef struct packed {
    alu_op_e    alu_op;
    op_a_sel_e  op_a_sel;
    op_b_sel_e  op_b_sel;
    imm_a_sel_e imm_a_sel;
    imm_b_sel_e imm_b_sel;
    logic       md_en;
    md_op_e     md_op;
    logic [1:0] md_signed;     // {op_b signed, op_a signed}
    logic       rf_we;
    logic       csr_access;
    csr_op_e    csr_op;
    logic       mem_req;
    logic       mem_we;
    mem_type_e  mem_type;
    logic       mem_sign_ext;
    logic       jump;
    logic       branch;
    logic       illegal;
    logic       ecall;
    logic       ebreak;
    logic       mret;
    logic       wfi;
  } rv_ctrl_t;

endpackage

//--- hw/rv_decode_stage.sv
// decode stage top: classifier, instruction queue and control decoder
`timescale 1ns/100ps

module rv_decode_stage import rv_isa_pkg::*; import rv_ctrl_pkg::*; #(
  parameter int QUEUE_DEPTH = 4
) (
  input  logic     clk,
  input  logic     arst_n_i,
  input  logic     instr_valid_i,
  input  insn_u    instr_i,
  input  logic     stall_i,
  output logic     ctrl_valid_o,  // min 3 cycles after instr_valid_i
  output rv_ctrl_t ctrl_o,
  output logic     queue_full_o
);

  logic        cls_valid;
  class_insn_t cls_insn;
  logic        q_valid;
  class_insn_t q_insn;
  logic        q_pop;

  insn_classifier u_classifier (
    .clk           (clk),
    .arst_n_i      (arst_n_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .cls_valid_o   (cls_valid),
    .cls_insn_o    (cls_insn)
  );

  insn_queue #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) u_queue (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .push_i      (cls_valid),
    .push_data_i (cls_insn),
    .pop_i       (q_pop),
    .valid_o     (q_valid),
    .data_o      (q_insn),
    .full_o      (queue_full_o)
  );

  ctrl_decoder u_decoder (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .q_valid_i    (q_valid),
    .q_insn_i     (q_insn),
    .stall_i      (stall_i),
    .pop_o        (q_pop),
    .ctrl_valid_o (ctrl_valid_o),
    .ctrl_o       (ctrl_o)
  );

endmodule

//--- hw/rv_isa_pkg.sv
// rv32 isa definitions: opcodes, format views, instruction union, classified queue entry
package rv_isa_pkg;

  localparam int XLEN = 32;  // instruction width

  //////////////////////////////////////////////////////////
  // major opcodes
  //////////////////////////////////////////////////////////
  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011,
    OPC_SYSTEM = 7'b1110011
  } opcode_e;

  //////////////////////////////////////////////////////////
  // format views, msb first
  //////////////////////////////////////////////////////////
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm12;  // also funct12 on system
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic [19:0] imm20;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  // one instruction word, read through whichever format fits
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    u_fmt_t u_fmt;
  } insn_u;

  // opcode class tag, set once by the classifier
  typedef enum logic [3:0] {
    CLS_LUI,
    CLS_AUIPC,
    CLS_JAL,
    CLS_JALR,
    CLS_BRANCH,
    CLS_LOAD,
    CLS_STORE,
    CLS_OP_IMM,
    CLS_OP,
    CLS_SYSTEM,
    CLS_ILLEGAL
  } insn_class_e;

  typedef struct packed {
    insn_u       insn;  // raw word
    insn_class_e cls;   // its class
  } class_insn_t;

endpackage

//--- rv_decode_stage.f
+incdir+tests
hw/rv_isa_pkg.sv
hw/rv_ctrl_pkg.sv
hw/insn_classifier.sv
hw/insn_queue.sv
hw/ctrl_decoder.sv
hw/rv_decode_stage.sv
tests/tb_clock_gen.sv
tests/tb_rv_decode_stage.sv

//--- tests/tb_clock_gen.sv
// testbench clock and reset generator
`timescale 1ns/100ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 20,
  parameter int RESET_CYCLES = 5
) (
  output logic clk_o,
  output logic arst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  initial begin
    arst_n_o = 1'b0;                        // held low from time 0
    repeat (RESET_CYCLES) @(posedge clk_o);
    arst_n_o <= 1'b1;
  end

endmodule

//--- tests/tb_ref_model.svh
// reference decode function, lfsr random source and instruction generator
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

logic [31:0] lfsr_state = 32'hd334fdc8;

// fibonacci lfsr, x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// n fresh bits, one lfsr step each
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] r;
  r = '0;
  for (int i = 0; i < n; i++) begin
    lfsr_state = lfsr_next(lfsr_state);
    r = {r[30:0], lfsr_state[0]};
  end
  return r;
endfunction

////////////////////////////////////////////////////////////
// expected control word, straight from the isa rules
////////////////////////////////////////////////////////////
function automatic rv_ctrl_t ref_decode(input logic [31:0] w);
  rv_ctrl_t    c;
  logic [2:0]  f3;
  logic [6:0]  f7;
  logic [11:0] f12;
  f3  = w[14:12];
  f7  = w[31:25];
  f12 = w[31:20];
  c        = '0;
  c.alu_op = ALU_SLTU;                       // idle operator
  case (w[6:0])
    OPC_LUI, OPC_AUIPC: begin                // 0 or pc, plus U imm
      c.op_a_sel  = (w[6:0] == OPC_LUI) ? OP_A_IMM : OP_A_CURRPC;
      c.op_b_sel  = OP_B_IMM;
      c.imm_b_sel = IMM_B_U;
      c.alu_op    = ALU_ADD;
      c.rf_we     = 1'b1;
    end
    OPC_JAL, OPC_JALR: begin                 // link = pc + 4
      c.jump      = 1'b1;
      c.op_a_sel  = OP_A_CURRPC;
      c.op_b_sel  = OP_B_IMM;
      c.imm_b_sel = IMM_B_PCINCR;
      c.alu_op    = ALU_ADD;
      c.rf_we     = 1'b1;
      c.illegal   = (w[6:0] == OPC_JALR) && (f3 != 3'b000);
    end
    OPC_BRANCH: begin
      c.branch = 1'b1;
      case (f3)
        3'd0: c.alu_op = ALU_EQ;
        3'd1: c.alu_op = ALU_NE;
        3'd4: c.alu_op = ALU_LTS;
        3'd5: c.alu_op = ALU_GES;
        3'd6: c.alu_op = ALU_LTU;
        3'd7: c.alu_op = ALU_GEU;
        default: c.illegal = 1'b1;
      endcase
    end
    OPC_LOAD, OPC_STORE: begin               // address = rs1 + imm
      c.mem_req  = 1'b1;
      c.alu_op   = ALU_ADD;
      c.op_b_sel = OP_B_IMM;
      if (f3[1:0] == 2'b00) c.mem_type = MEM_BYTE;
      else if (f3[1:0] == 2'b01) c.mem_type = MEM_HALF;
      else c.mem_type = MEM_WORD;
      if (w[6:0] == OPC_LOAD) begin
        c.rf_we        = 1'b1;
        c.mem_sign_ext = ~f3[2];
        c.illegal      = (f3[1:0] == 2'b11) || (f3 == 3'b110);
      end else begin
        c.mem_we    = 1'b1;
        c.imm_b_sel = IMM_B_S;
        c.illegal   = f3[2] || (f3[1:0] == 2'b11);
      end
    end
    OPC_OP_IMM: begin
      c.op_b_sel = OP_B_IMM;
      c.rf_we    = 1'b1;
      case (f3)
        3'd0: c.alu_op = ALU_ADD;
        3'd2: c.alu_op = ALU_SLTS;
        3'd3: c.alu_op = ALU_SLTU;
        3'd4: c.alu_op = ALU_XOR;
        3'd6: c.alu_op = ALU_OR;
        3'd7: c.alu_op = ALU_AND;
        3'd1: begin
          c.alu_op  = ALU_SLL;
          c.illegal = (f7 != 7'h00);
        end
        default: begin                       // srli / srai
          if (f7 == 7'h00) c.alu_op = ALU_SRL;
          else if (f7 == 7'h20) c.alu_op = ALU_SRA;
          else c.illegal = 1'b1;
        end
      endcase
    end
    OPC_OP: begin
      c.rf_we = 1'b1;
      if (f7 == 7'h00) begin
        case (f3)
          3'd0: c.alu_op = ALU_ADD;
          3'd1: c.alu_op = ALU_SLL;
          3'd2: c.alu_op = ALU_SLTS;
          3'd3: c.alu_op = ALU_SLTU;
          3'd4: c.alu_op = ALU_XOR;
          3'd5: c.alu_op = ALU_SRL;
          3'd6: c.alu_op = ALU_OR;
          default: c.alu_op = ALU_AND;
        endcase
      end else if (f7 == 7'h20 && f3 == 3'd0) begin
        c.alu_op = ALU_SUB;
      end else if (f7 == 7'h20 && f3 == 3'd5) begin
        c.alu_op = ALU_SRA;
      end else if (f7 == 7'h01) begin        // mul / div / rem
        c.md_en  = 1'b1;
        c.alu_op = ALU_ADD;
        c.md_op  = md_op_e'({f3[2], f3[2] ? f3[1] : (f3[1:0] != 2'b00)});
        if (f3 == 3'd1 || f3 == 3'd4 || f3 == 3'd6) c.md_signed = 2'b11;
        else if (f3 == 3'd2) c.md_signed = 2'b01;
      end else begin
        c.illegal = 1'b1;
      end
    end
    OPC_SYSTEM: begin
      if (f3 == 3'b000) begin
        c.ecall   = (f12 == 12'h000);
        c.ebreak  = (f12 == 12'h001);
        c.mret    = (f12 == 12'h302);
        c.wfi     = (f12 == 12'h105);
        c.illegal = !(c.ecall || c.ebreak || c.mret || c.wfi);
      end else begin                         // csr ops, op codes match funct3[1:0]
        c.csr_access = 1'b1;
        c.rf_we      = 1'b1;
        c.op_b_sel   = OP_B_IMM;
        c.imm_a_sel  = IMM_A_Z;
        c.op_a_sel   = f3[2] ? OP_A_IMM : OP_A_REG;
        c.csr_op     = csr_op_e'(f3[1:0]);
        c.illegal    = (f3[1:0] == 2'b00);
      end
    end
    default: c.illegal = 1'b1;               // unknown or compressed space
  endcase
  if (c.illegal) begin                       // no state change
    c.rf_we   = 1'b0;
    c.mem_req = 1'b0;
    c.md_en   = 1'b0;
    c.jump    = 1'b0;
    c.branch  = 1'b0;
    c.csr_op  = CSR_NONE;
  end
  return c;
endfunction

// legal opcodes with random funct fields, plus some raw random words
function automatic logic [31:0] gen_insn();
  logic [31:0] w;
  logic [31:0] pick;
  logic [31:0] sel;
  w    = rand_bits(32);
  pick = rand_bits(4);
  sel  = rand_bits(3);
  case (pick)
    0:         w[6:0] = OPC_LUI;
    1:         w[6:0] = OPC_AUIPC;
    2:         w[6:0] = OPC_JAL;
    3:         w[6:0] = OPC_JALR;
    4:         w[6:0] = OPC_BRANCH;
    5:         w[6:0] = OPC_LOAD;
    6:         w[6:0] = OPC_STORE;
    7, 8:      w[6:0] = OPC_OP_IMM;
    9, 10, 11: w[6:0] = OPC_OP;
    12, 13:    w[6:0] = OPC_SYSTEM;
    default:   ;                             // raw word
  endcase
  // steer funct7 toward the legal values
  if (w[6:0] == OPC_OP || w[6:0] == OPC_OP_IMM) begin
    case (sel[1:0])
      2'd0:    w[31:25] = 7'h00;
      2'd1:    w[31:25] = 7'h20;
      2'd2:    w[31:25] = 7'h01;
      default: ;
    endcase
  end
  if (w[6:0] == OPC_SYSTEM && sel[2]) begin  // privileged ops
    w[14:12] = 3'b000;
    case (sel[1:0])
      2'd0:    w[31:20] = 12'h000;
      2'd1:    w[31:20] = 12'h001;
      2'd2:    w[31:20] = 12'h302;
      default: w[31:20] = 12'h105;
    endcase
  end
  if (w[6:0] == OPC_JALR && sel[0])
    w[14:12] = 3'b000;
  return w;
endfunction

`endif

//--- tests/tb_rv_decode_stage.sv
// testbench top with random instruction stream, expected queue and control word compare
`timescale 1ns/100ps

module tb_rv_decode_stage import rv_isa_pkg::*; import rv_ctrl_pkg::*; ();

  localparam int QUEUE_DEPTH   = 4;
  localparam int N_INSN        = 600;
  localparam int RESET_TIMEOUT = 50;
  localparam int SLOT_TIMEOUT  = 200;   // cycles without a free slot
  localparam int DRAIN_TIMEOUT = 200;

  typedef struct packed {
    logic [31:0] word;
    rv_ctrl_t    ctrl;
  } exp_entry_t;

  logic     clk;
  logic     arst_n;
  logic     instr_valid;
  insn_u    instr;
  logic     stall;
  logic     ctrl_valid;
  rv_ctrl_t ctrl;
  logic     queue_full;

  exp_entry_t exp_q[$];                 // pushed at send and popped per ctrl_valid_o
  int sent         = 0;
  int recv_count   = 0;
  int value_errs   = 0;
  int order_errs   = 0;
  int stall_errs   = 0;
  int timeout_errs = 0;

  `include "tb_ref_model.svh"

  tb_clock_gen #(.PERIOD_NS(20), .RESET_CYCLES(5)) u_clk_gen (
    .clk_o    (clk),
    .arst_n_o (arst_n)
  );

  rv_decode_stage #(.QUEUE_DEPTH(QUEUE_DEPTH)) uut (
    .clk           (clk),
    .arst_n_i      (arst_n),
    .instr_valid_i (instr_valid),
    .instr_i       (instr),
    .stall_i       (stall),
    .ctrl_valid_o  (ctrl_valid),
    .ctrl_o        (ctrl),
    .queue_full_o  (queue_full)
  );

  ////////////////////////////////////////////////////////////
  // compare helpers
  ////////////////////////////////////////////////////////////
  task automatic compare_field(input string name, input logic [31:0] got,
                               input logic [31:0] expd, input logic [31:0] word);
    assert (got === expd) else begin
      $display("FAIL ctrl_o.%s got 0x%0h expected 0x%0h (insn 0x%08h)", name, got, expd, word);
      value_errs++;
    end
  endtask

  task automatic check_ctrl(input rv_ctrl_t got, input exp_entry_t e);
    compare_field("alu_op", 32'(got.alu_op), 32'(e.ctrl.alu_op), e.word);
    compare_field("op_a_sel", 32'(got.op_a_sel), 32'(e.ctrl.op_a_sel), e.word);
    compare_field("op_b_sel", 32'(got.op_b_sel), 32'(e.ctrl.op_b_sel), e.word);
    compare_field("imm_a_sel", 32'(got.imm_a_sel), 32'(e.ctrl.imm_a_sel), e.word);
    compare_field("imm_b_sel", 32'(got.imm_b_sel), 32'(e.ctrl.imm_b_sel), e.word);
    compare_field("md_en", 32'(got.md_en), 32'(e.ctrl.md_en), e.word);
    compare_field("md_op", 32'(got.md_op), 32'(e.ctrl.md_op), e.word);
    compare_field("md_signed", 32'(got.md_signed), 32'(e.ctrl.md_signed), e.word);
    compare_field("rf_we", 32'(got.rf_we), 32'(e.ctrl.rf_we), e.word);
    compare_field("csr_access", 32'(got.csr_access), 32'(e.ctrl.csr_access), e.word);
    compare_field("csr_op", 32'(got.csr_op), 32'(e.ctrl.csr_op), e.word);
    compare_field("mem_req", 32'(got.mem_req), 32'(e.ctrl.mem_req), e.word);
    compare_field("mem_we", 32'(got.mem_we), 32'(e.ctrl.mem_we), e.word);
    compare_field("mem_type", 32'(got.mem_type), 32'(e.ctrl.mem_type), e.word);
    compare_field("mem_sign_ext", 32'(got.mem_sign_ext), 32'(e.ctrl.mem_sign_ext), e.word);
    compare_field("jump", 32'(got.jump), 32'(e.ctrl.jump), e.word);
    compare_field("branch", 32'(got.branch), 32'(e.ctrl.branch), e.word);
    compare_field("illegal", 32'(got.illegal), 32'(e.ctrl.illegal), e.word);
    compare_field("ecall", 32'(got.ecall), 32'(e.ctrl.ecall), e.word);
    compare_field("ebreak", 32'(got.ebreak), 32'(e.ctrl.ebreak), e.word);
    compare_field("mret", 32'(got.mret), 32'(e.ctrl.mret), e.word);
    compare_field("wfi", 32'(got.wfi), 32'(e.ctrl.wfi), e.word);
  endtask

  // outputs sampled on the falling edge
  initial begin : compare
    logic       stall_seen;
    logic       iv_d1;
    logic       iv_d2;
    int         q_cnt;
    exp_entry_t e;
    stall_seen = 1'b0;
    iv_d1      = 1'b0;
    iv_d2      = 1'b0;
    q_cnt      = 0;
    forever begin
      @(negedge clk);
      if (arst_n === 1'b1) begin
        if (stall_seen) begin                // decoder saw stall at the last edge
          assert (!ctrl_valid) else begin
            $display("ctrl_valid_o went high in the cycle after stall_i");
            stall_errs++;
          end
        end
        if (ctrl_valid) begin
          assert (exp_q.size() != 0) else begin
            $display("ctrl_valid_o went high with no instruction outstanding");
            order_errs++;
          end
          if (exp_q.size() != 0) begin
            e = exp_q.pop_front();
            check_ctrl(ctrl, e);
          end
          recv_count++;
        end
        // queue fill level, a word lands two edges after its strobe
        q_cnt = q_cnt + int'(iv_d2) - int'(ctrl_valid);
        assert (queue_full === (q_cnt == QUEUE_DEPTH)) else begin
          $display("FAIL queue_full_o got 0x%0h expected 0x%0h",
                   queue_full, (q_cnt == QUEUE_DEPTH));
          value_errs++;
        end
      end
      stall_seen = stall;
      iv_d2      = iv_d1;
      iv_d1      = instr_valid;
    end
  end

  ////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////
  initial begin : main
    logic [31:0] w;
    logic [31:0] coin;
    logic [31:0] stall_lvl;
    exp_entry_t  e;
    int          idle;
    instr_valid = 1'b0;
    instr       = '0;
    stall       = 1'b0;
    idle        = 0;

    while (arst_n !== 1'b1 && timeout_errs == 0) begin
      @(posedge clk);
      idle++;
      if (idle > RESET_TIMEOUT) begin
        $display("timeout: reset was never released");
        timeout_errs++;
      end
    end

    @(negedge clk);                          // idle state after reset
    assert (ctrl_valid === 1'b0) else begin
      $display("FAIL ctrl_valid_o got 0x%0h expected 0x0 after reset", ctrl_valid);
      value_errs++;
    end
    assert (queue_full === 1'b0) else begin
      $display("FAIL queue_full_o got 0x%0h expected 0x0 after reset", queue_full);
      value_errs++;
    end
    assert (ctrl === '0) else begin
      $display("FAIL ctrl_o got 0x%0h expected 0x0 after reset", ctrl);
      value_errs++;
    end

    idle = 0;
    while (sent < N_INSN && timeout_errs == 0) begin
      @(posedge clk);
      stall_lvl = ((sent / 64) % 2 == 1) ? 32'd6 : 32'd2;   // heavy phases fill the queue
      stall <= (rand_bits(3) < stall_lvl);
      coin = rand_bits(2);
      // outstanding count keeps the two-slot slack on top of queue_full_o
      if (!queue_full && (sent - recv_count) < QUEUE_DEPTH && coin != 0) begin
        w           = gen_insn();
        e.word      = w;
        e.ctrl      = ref_decode(w);
        instr_valid <= 1'b1;
        instr       <= w;
        exp_q.push_back(e);
        sent++;
        idle = 0;
      end else begin
        instr_valid <= 1'b0;
        idle++;
        if (idle > SLOT_TIMEOUT) begin
          $display("timeout: no free queue slot for %0d cycles", idle);
          timeout_errs++;
        end
      end
    end

    @(posedge clk);
    instr_valid <= 1'b0;
    stall       <= 1'b0;
    idle = 0;
    while (recv_count < sent && timeout_errs == 0) begin
      @(posedge clk);
      idle++;
      if (idle > DRAIN_TIMEOUT) begin
        $display("timeout: %0d instructions never came out", sent - recv_count);
        timeout_errs++;
      end
    end
    repeat (4) @(posedge clk);               // window for stray valids

    assert (exp_q.size() == 0 && recv_count == sent) else begin
      $display("instruction count mismatch, %0d sent and %0d decoded", sent, recv_count);
      order_errs++;
    end

    $display("errors: value %0d, order %0d, stall %0d, timeout %0d",
             value_errs, order_errs, stall_errs, timeout_errs);
    if (value_errs + order_errs + stall_errs + timeout_errs == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule
